/* source/vdma_wr_pkg.sv */
package vdma_wr_pkg;

    localparam int NUM_CH       = 4;
    localparam int BURST_LEN    = 16;
    localparam int DATA_W       = 256;
    localparam int ADDR_W       = 28;
    localparam int ADDR_STEP    = BURST_LEN * 8;     // 8 words of 32 bits per beat
    localparam int FRAME_OFFSET = 30000;             // second frame slot
    localparam int CH_OFFSET    = 2 * FRAME_OFFSET;  // one region holds both slots

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [1:0]        ch_idx_t;
    typedef logic [NUM_CH-1:0] ch_mask_t;
    typedef logic [3:0]        beat_cnt_t;
    typedef logic [19:0]       line_ofs_t;           // offset within a frame slot

    // arbiter states
    typedef enum logic [1:0] {
        ST_PAUSE,
        ST_POLL,
        ST_ADDR,
        ST_DATA
    } arb_state_t;

    // aw channel, len/size/burst/id are fixed in the controller wrapper
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
    } axi_aw_t;

    // w channel, full strobes assumed
    typedef struct packed {
        logic  wvalid;
        logic  wlast;
        data_t wdata;
    } axi_w_t;

endpackage

/* source/wr_arb_fsm.sv */
`timescale 1ns/1ps

module wr_arb_fsm import vdma_wr_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ch_mask_t ch_ready,
    input  addr_t    ch_addr [NUM_CH],
    input  logic     awready,
    input  logic     burst_done,
    input  logic     pause_req,
    output axi_aw_t  aw,
    output ch_mask_t aw_accept,
    output ch_idx_t  cur_ch,
    output logic     data_phase,
    output logic     pause_ack
);

    arb_state_t state;
    arb_state_t state_nxt;
    addr_t      awaddr_q;
    logic       aw_fire;

    function automatic ch_idx_t next_ch(input ch_idx_t ch);
        if (ch == ch_idx_t'(NUM_CH - 1)) begin
            return '0;
        end
        return ch + 1'b1;
    endfunction

    always_comb begin
        state_nxt = state;
        case (state)
            ST_POLL: begin
                if (pause_req) begin
                    state_nxt = ST_PAUSE;   // stop between bursts
                end else if (ch_ready[cur_ch]) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (awready) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                if (burst_done) begin
                    state_nxt = pause_req ? ST_PAUSE : ST_POLL;
                end
            end
            ST_PAUSE: begin
                if (!pause_req) begin
                    state_nxt = ST_POLL;
                end
            end
            default: state_nxt = ST_POLL;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_POLL;
        end else begin
            state <= state_nxt;
        end
    end

    // round-robin pointer, restarts at channel 0 after a pause
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cur_ch <= '0;
        end else begin
            case (state)
                ST_POLL: begin
                    if (!pause_req && !ch_ready[cur_ch]) begin
                        cur_ch <= next_ch(cur_ch);
                    end
                end
                ST_DATA: begin
                    if (burst_done && !pause_req) begin
                        cur_ch <= next_ch(cur_ch);
                    end
                end
                ST_PAUSE: begin
                    if (!pause_req) begin
                        cur_ch <= '0;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_POLL && state_nxt == ST_ADDR) begin
            awaddr_q <= ch_addr[cur_ch];   // held until awready
        end
    end

    assign aw_fire    = (state == ST_ADDR) && awready;
    assign aw_accept  = aw_fire ? (ch_mask_t'(1'b1) << cur_ch) : '0;
    assign aw         = '{awvalid: (state == ST_ADDR), awaddr: awaddr_q};
    assign data_phase = (state == ST_DATA);
    assign pause_ack  = (state == ST_PAUSE);

endmodule

/* source/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter import vdma_wr_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic beat_fire,
    output logic last_beat,
    output logic burst_done
);

    beat_cnt_t cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (beat_fire) begin
            if (last_beat) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // wlast level while the final beat waits for wready
    assign last_beat = (cnt == beat_cnt_t'(BURST_LEN - 1));

    // final beat accepted
    assign burst_done = beat_fire && last_beat;

endmodule

/* source/chan_addr_gen.sv */
`timescale 1ns/1ps

module chan_addr_gen import vdma_wr_pkg::*; #(
    parameter addr_t CH_BASE = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  vsync,
    input  logic  aw_accept,
    output addr_t addr
);

    logic      vs_sync;
    logic      vs_dly;
    logic      vs_rise;
    logic      frame_slot;
    line_ofs_t line_ofs;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vs_sync <= 1'b0;
            vs_dly  <= 1'b0;
        end else begin
            vs_sync <= vsync;
            vs_dly  <= vs_sync;
        end
    end

    assign vs_rise = vs_sync && !vs_dly;

    // new frame goes to the other slot
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            frame_slot <= 1'b0;
        end else if (vs_rise) begin
            frame_slot <= !frame_slot;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_ofs <= '0;
        end else if (vs_rise) begin
            line_ofs <= '0;                 // clear beats a same-cycle advance
        end else if (aw_accept) begin
            line_ofs <= line_ofs + line_ofs_t'(ADDR_STEP);
        end
    end

    assign addr = CH_BASE
                + (frame_slot ? addr_t'(FRAME_OFFSET) : addr_t'(0))
                + addr_t'(line_ofs);

endmodule

/* source/write_data_path.sv */
`timescale 1ns/1ps

module write_data_path import vdma_wr_pkg::*; (
    input  ch_idx_t  cur_ch,
    input  logic     data_phase,
    input  data_t    ch_data [NUM_CH],
    input  logic     wready,
    input  logic     last_beat,
    output axi_w_t   w,
    output ch_mask_t ch_rd_en,
    output logic     beat_fire
);

    assign beat_fire = data_phase && wready;

    // fwft buffers, so the head word is already on ch_data
    always_comb begin
        w.wvalid = data_phase;
        w.wlast  = data_phase && last_beat;
        w.wdata  = ch_data[cur_ch];
    end

    // pop only on an accepted beat, wdata holds through a stall
    always_comb begin
        ch_rd_en         = '0;
        ch_rd_en[cur_ch] = beat_fire;
    end

endmodule

/* source/vdma_wr_top.sv */
`timescale 1ns/1ps

module vdma_wr_top import vdma_wr_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ch_mask_t ch_ready,
    input  ch_mask_t ch_vsync,
    input  data_t    ch_data [NUM_CH],
    output ch_mask_t ch_rd_en,
    input  logic     pause_req,
    output logic     pause_ack,
    output axi_aw_t  aw,
    input  logic     awready,
    output axi_w_t   w,
    input  logic     wready,
    input  logic     bvalid,    // write response accepted and dropped
    output logic     bready
);

    addr_t    ch_addr [NUM_CH];
    ch_mask_t aw_accept;
    ch_idx_t  cur_ch;
    logic     data_phase;
    logic     beat_fire;
    logic     last_beat;
    logic     burst_done;

    wr_arb_fsm i_arb (
        .clk        (clk),
        .rst        (rst),
        .ch_ready   (ch_ready),
        .ch_addr    (ch_addr),
        .awready    (awready),
        .burst_done (burst_done),
        .pause_req  (pause_req),
        .aw         (aw),
        .aw_accept  (aw_accept),
        .cur_ch     (cur_ch),
        .data_phase (data_phase),
        .pause_ack  (pause_ack)
    );

    beat_counter i_beat (
        .clk        (clk),
        .rst        (rst),
        .beat_fire  (beat_fire),
        .last_beat  (last_beat),
        .burst_done (burst_done)
    );

    write_data_path i_wdp (
        .cur_ch     (cur_ch),
        .data_phase (data_phase),
        .ch_data    (ch_data),
        .wready     (wready),
        .last_beat  (last_beat),
        .w          (w),
        .ch_rd_en   (ch_rd_en),
        .beat_fire  (beat_fire)
    );

    // one address generator per channel region
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        chan_addr_gen #(
            .CH_BASE (addr_t'(i * CH_OFFSET))
        ) i_addr (
            .clk       (clk),
            .rst       (rst),
            .vsync     (ch_vsync[i]),
            .aw_accept (aw_accept[i]),
            .addr      (ch_addr[i])
        );
    end

    assign bready = 1'b1;

endmodule

/* dv/axi_wr_sink.sv */
`timescale 1ns/1ps

module axi_wr_sink import vdma_wr_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall_en,
    input  axi_aw_t aw,
    output logic    awready,
    input  axi_w_t  w,
    output logic    wready
);

    integer seed = 37;
    addr_t  addr_q [$];
    data_t  beat_q [$];
    logic   last_q [$];

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            addr_q.delete();
            beat_q.delete();
            last_q.delete();
        end else begin
            if (aw.awvalid && awready) begin
                addr_q.push_back(aw.awaddr);
            end
            if (w.wvalid && wready) begin
                beat_q.push_back(w.wdata);
                last_q.push_back(w.wlast);
            end
            // about one cycle in three stalled
            awready <= stall_en ? ($random(seed) % 3 != 0) : 1'b1;
            wready  <= stall_en ? ($random(seed) % 3 != 0) : 1'b1;
        end
    end

endmodule

/* dv/tb_vdma_wr.sv */
`timescale 1ns/1ps

module tb_vdma_wr import vdma_wr_pkg::*; ();

    localparam int MAX_CYCLES = 20000;   // tests take about 3000

    logic     clk = 1'b0;
    logic     rst;
    ch_mask_t ch_ready;
    ch_mask_t ch_vsync;
    data_t    ch_data [NUM_CH];
    ch_mask_t ch_rd_en;
    logic     pause_req;
    logic     pause_ack;
    axi_aw_t  aw;
    logic     awready;
    axi_w_t   w;
    logic     wready;
    logic     bvalid;
    logic     bready;
    logic     stall_en;

    int       pop_cnt [NUM_CH];
    int       exp_pop [NUM_CH];
    int       exp_ofs [NUM_CH];
    int       exp_slot [NUM_CH];
    ch_idx_t  last_ch;
    ch_mask_t ready_set;
    int       errors = 0;
    int       checks = 0;
    int       tests = 0;
    int       cycles = 0;

    vdma_wr_top i_dut (
        .clk, .rst, .ch_ready, .ch_vsync, .ch_data, .ch_rd_en, .pause_req, .pause_ack,
        .aw, .awready, .w, .wready, .bvalid, .bready
    );

    axi_wr_sink i_sink (.clk, .rst, .stall_en, .aw, .awready, .w, .wready);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // channel word is the channel number above a running pop count
    function automatic data_t word_of(input int ch, input int n);
        return (data_t'(ch) << 32) | data_t'(n);
    endfunction

    // fwft channel models
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                pop_cnt[i] <= 0;
            end
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (ch_rd_en[i]) begin
                    pop_cnt[i] <= pop_cnt[i] + 1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            ch_data[i] = word_of(i, pop_cnt[i]);
        end
    end

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic check_ch(input ch_idx_t got, input ch_idx_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // next ready channel in round-robin order after last
    function automatic ch_idx_t next_ready(input ch_idx_t last, input ch_mask_t mask);
        ch_idx_t c;
        c = last;
        for (int n = 0; n < NUM_CH; n++) begin
            c = c + 1'b1;
            if (mask[c]) begin
                return c;
            end
        end
        return c;
    endfunction

    task automatic reset_dut(input ch_mask_t mask);
        @(posedge clk);
        rst       <= 1'b0;
        ch_ready  <= mask;           // ready before the first poll
        ch_vsync  <= '0;
        pause_req <= 1'b0;
        stall_en  <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        for (int c = 0; c < NUM_CH; c++) begin
            exp_pop[c]  = 0;
            exp_ofs[c]  = 0;
            exp_slot[c] = 0;
        end
        last_ch   = ch_idx_t'(NUM_CH - 1);
        ready_set = mask;
        @(posedge clk);
    endtask

    task automatic set_ready(input ch_mask_t mask);
        ready_set = mask;
        @(posedge clk);
        ch_ready <= mask;
    endtask

    task automatic check_burst(input ch_idx_t exp_ch);
        addr_t exp_addr;
        data_t beat;
        exp_addr = addr_t'(int'(exp_ch) * CH_OFFSET + exp_slot[exp_ch] * FRAME_OFFSET
                           + exp_ofs[exp_ch]);
        while (i_sink.addr_q.size() == 0 || i_sink.beat_q.size() < BURST_LEN) @(posedge clk);
        check_addr(i_sink.addr_q.pop_front(), exp_addr, "burst address");
        for (int k = 0; k < BURST_LEN; k++) begin
            beat = i_sink.beat_q.pop_front();
            if (k == 0) begin
                check_ch(ch_idx_t'(beat >> 32), exp_ch, "burst channel");
            end
            check_data(beat, word_of(exp_ch, exp_pop[exp_ch]), "beat data");
            check_bit(i_sink.last_q.pop_front(), k == BURST_LEN - 1, "wlast");
            exp_pop[exp_ch]++;
        end
        exp_ofs[exp_ch] += ADDR_STEP;
    endtask

    task automatic check_next();
        ch_idx_t c;
        c = next_ready(last_ch, ready_set);
        check_burst(c);
        last_ch = c;
    endtask

    // stop new bursts, let the last one finish, check what is left
    task automatic quiesce();
        @(posedge clk);
        ch_ready <= '0;
        @(posedge clk);
        while (aw.awvalid || w.wvalid) @(posedge clk);
        while (i_sink.addr_q.size() > 0) check_next();
        for (int c = 0; c < NUM_CH; c++) begin
            check_int(pop_cnt[c], exp_pop[c], "pop count");
        end
        check_int(i_sink.beat_q.size(), 0, "beats outside a burst");
    endtask

    task automatic pulse_vsync(input int ch);
        @(posedge clk);
        ch_vsync[ch] <= 1'b1;
        repeat (2) @(posedge clk);
        ch_vsync[ch] <= 1'b0;
        repeat (4) @(posedge clk);   // sync and edge detect
        exp_slot[ch] ^= 1;
        exp_ofs[ch] = 0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic test_single();
        int errs;
        errs = errors;
        reset_dut('0);
        check_bit(aw.awvalid, 1'b0, "awvalid after reset");
        check_bit(w.wvalid, 1'b0, "wvalid after reset");
        check_bit(|ch_rd_en, 1'b0, "ch_rd_en after reset");
        check_bit(pause_ack, 1'b0, "pause_ack after reset");
        check_bit(bready, 1'b1, "bready");
        set_ready(4'b0100);
        while (!aw.awvalid) @(posedge clk);
        ch_ready <= '0;              // one burst only
        quiesce();
        check_int(pop_cnt[2], BURST_LEN, "channel 2 pops");
        report_test("single_channel", errs);
    endtask

    task automatic test_round_robin();
        int errs;
        errs = errors;
        reset_dut('1);
        repeat (8) check_next();
        quiesce();
        report_test("round_robin", errs);
    endtask

    task automatic test_frame_slots();
        int errs;
        errs = errors;
        reset_dut(4'b0011);
        repeat (2) check_next();
        quiesce();
        pulse_vsync(1);
        set_ready(4'b0010);
        check_next();
        quiesce();
        pulse_vsync(1);
        set_ready(4'b0010);
        check_next();
        quiesce();
        set_ready(4'b0001);          // channel 0 offset carries on
        check_next();
        quiesce();
        report_test("frame_slots", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = errors;
        reset_dut('1);
        stall_en <= 1'b1;
        pulse_vsync(1);
        repeat (8) check_next();
        quiesce();
        stall_en <= 1'b0;
        report_test("backpressure", errs);
    endtask

    task automatic test_pause();
        int errs;
        errs = errors;
        reset_dut(4'b0010);
        while (!w.wvalid) @(posedge clk);
        pause_req <= 1'b1;
        while (!pause_ack) @(posedge clk);
        check_int(i_sink.addr_q.size(), 1, "bursts before pause");
        check_int(i_sink.beat_q.size(), BURST_LEN, "beats before pause");
        check_next();
        set_ready('1);               // channel 0 waits behind the pause
        repeat (10) begin
            @(posedge clk);
            check_bit(aw.awvalid, 1'b0, "awvalid while paused");
        end
        pause_req <= 1'b0;
        while (pause_ack) @(posedge clk);
        last_ch = ch_idx_t'(NUM_CH - 1);   // restarts at channel 0
        check_next();
        quiesce();
        report_test("pause", errs);
    endtask

    initial begin
        rst       = 1'b0;
        ch_ready  = '0;
        ch_vsync  = '0;
        pause_req = 1'b0;
        bvalid    = 1'b0;
        stall_en  = 1'b0;
        test_single();
        test_round_robin();
        test_frame_slots();
        test_backpressure();
        test_pause();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* list.f */
source/vdma_wr_pkg.sv
source/wr_arb_fsm.sv
source/beat_counter.sv
source/chan_addr_gen.sv
source/write_data_path.sv
source/vdma_wr_top.sv
dv/axi_wr_sink.sv
dv/tb_vdma_wr.sv

/* Bender.yml */
package:
  name: vdma_wr

sources:
  - files:
      - source/vdma_wr_pkg.sv
      - source/wr_arb_fsm.sv
      - source/beat_counter.sv
      - source/chan_addr_gen.sv
      - source/write_data_path.sv
      - source/vdma_wr_top.sv
  - target: test
    files:
      - dv/axi_wr_sink.sv
      - dv/tb_vdma_wr.sv
